// ==== rtl/eeprom_pkg.sv ====
package eeprom_pkg;

    // 2K x 8 in the 24C16 style
    typedef logic [10:0] eeprom_addr_t;
    typedef logic [7:0]  byte_t;

    // commands for the byte engine
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } i2c_cmd_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;   // control byte upper nibble

    typedef enum logic [3:0]
    {
        Idle,
        Start,
        CtrlWrite,
        AddrWrite,
        DataWrite,
        Restart,
        CtrlRead,
        DataRead,
        Stop,
        Ackn
    } seq_state_t;

    typedef enum logic [2:0]
    {
        ENG_IDLE,
        ENG_START,
        ENG_STOP,
        ENG_WRITE,
        ENG_READ
    } eng_state_t;

endpackage

// ==== rtl/i2c_byte_engine.sv ====
module i2c_byte_engine
#(
    parameter int QUARTER_CYCLES = 2
)
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::i2c_cmd_t cmd,
    input  eeprom_pkg::byte_t    tx_byte,
    input  logic                 master_nack,
    input  logic                 sda_in,
    output logic                 busy,
    output logic                 cmd_done,
    output eeprom_pkg::byte_t    rx_byte,
    output logic                 slave_nack,
    output logic                 scl,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    eng_state_t    state;
    logic [QW-1:0] q_cnt;
    logic [1:0]    quarter;     // 0,3 scl low  1,2 scl high
    logic [3:0]    bit_cnt;     // 8 is the ack bit
    byte_t         shreg;
    logic          nack_bit;
    logic          accept;
    logic          q_end;
    logic          last_bit;

    assign accept   = (state == ENG_IDLE) && cmd_valid;
    assign q_end    = (state != ENG_IDLE) && (q_cnt == QW'(QUARTER_CYCLES - 1));
    assign last_bit = (state == ENG_START) || (state == ENG_STOP) || (bit_cnt == 4'd8);
    assign rx_byte  = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= ENG_IDLE;
            busy       <= 1'b0;
            cmd_done   <= 1'b0;
            slave_nack <= 1'b0;
            scl        <= 1'b1;     // idle bus
            sda_oe     <= 1'b0;
            q_cnt      <= '0;
            quarter    <= 2'd0;
            bit_cnt    <= 4'd0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (accept)
            begin
                busy       <= 1'b1;
                slave_nack <= 1'b0;
                q_cnt      <= '0;
                quarter    <= 2'd0;
                bit_cnt    <= 4'd0;
                case (cmd)
                    CMD_START:
                    begin
                        state  <= ENG_START;
                        sda_oe <= 1'b0;     // scl keeps its level
                    end
                    CMD_STOP:
                    begin
                        state  <= ENG_STOP;
                        scl    <= 1'b0;
                        sda_oe <= 1'b1;
                    end
                    CMD_WRITE:
                    begin
                        state  <= ENG_WRITE;
                        scl    <= 1'b0;
                        sda_oe <= ~tx_byte[7];  // msb first
                    end
                    default:
                    begin
                        state  <= ENG_READ;
                        scl    <= 1'b0;
                        sda_oe <= 1'b0;
                    end
                endcase
            end
            else if (q_end)
            begin
                q_cnt   <= '0;
                quarter <= quarter + 2'd1;
                case (quarter)
                    2'd0:
                        scl <= 1'b1;
                    2'd1:
                    begin
                        // middle of scl high
                        if (state == ENG_START)
                            sda_oe <= 1'b1;
                        else if (state == ENG_STOP)
                            sda_oe <= 1'b0;
                        else if (state == ENG_WRITE && bit_cnt == 4'd8)
                            slave_nack <= sda_in;
                    end
                    2'd2:
                    begin
                        if (state != ENG_STOP)
                            scl <= 1'b0;
                    end
                    default:
                    begin
                        if (last_bit)
                        begin
                            state    <= ENG_IDLE;
                            busy     <= 1'b0;
                            cmd_done <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            // set up next bit while scl is low
                            if (state == ENG_WRITE)
                                sda_oe <= (bit_cnt == 4'd7) ? 1'b0 : ~shreg[6];
                            else
                                sda_oe <= (bit_cnt == 4'd7) ? ~nack_bit : 1'b0;
                        end
                    end
                endcase
            end
            else if (state != ENG_IDLE)
            begin
                q_cnt <= q_cnt + 1'b1;
            end
        end
    end

    // shift register for both write and read
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            shreg    <= tx_byte;
            nack_bit <= master_nack;
        end
        else if (q_end && quarter == 2'd1 && state == ENG_READ && bit_cnt < 4'd8)
        begin
            shreg <= {shreg[6:0], sda_in};
        end
        else if (q_end && quarter == 2'd3 && state == ENG_WRITE)
        begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

// ==== rtl/eeprom_sequencer.sv ====
module eeprom_sequencer
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t        wdata,
    input  logic                     busy,
    input  logic                     cmd_done,
    input  eeprom_pkg::byte_t        rx_byte,
    input  logic                     slave_nack,
    output logic                     ack,
    output logic                     nack,
    output eeprom_pkg::byte_t        rdata,
    output logic                     cmd_valid,
    output eeprom_pkg::i2c_cmd_t     cmd,
    output eeprom_pkg::byte_t        tx_byte,
    output logic                     master_nack
);
    import eeprom_pkg::*;

    seq_state_t   state;
    seq_state_t   next_state;
    logic         is_read;
    logic         issued;       // command of this state already sent
    logic         nack_flag;
    logic         issue;
    eeprom_addr_t addr_r;
    byte_t        wdata_r;
    i2c_cmd_t     state_cmd;
    byte_t        state_byte;

    assign ack  = (state == Ackn);
    assign nack = nack_flag;

    assign issue = (state != Idle) && (state != Ackn) && !cmd_done && !issued && !busy;

    // command and byte for each state
    always_comb
    begin
        state_cmd  = CMD_WRITE;
        state_byte = wdata_r;
        case (state)
            Start, Restart:
                state_cmd = CMD_START;
            CtrlWrite:
                state_byte = {DEVICE_CODE, addr_r[10:8], 1'b0};
            AddrWrite:
                state_byte = addr_r[7:0];
            CtrlRead:
                state_byte = {DEVICE_CODE, addr_r[10:8], 1'b1};
            DataRead:
                state_cmd = CMD_READ;
            Stop:
                state_cmd = CMD_STOP;
            default: ;
        endcase
    end

    // a missing device ack goes straight to stop
    always_comb
    begin
        next_state = Stop;
        case (state)
            Start:
                next_state = CtrlWrite;
            CtrlWrite:
                if (!slave_nack)
                    next_state = AddrWrite;
            AddrWrite:
                if (!slave_nack)
                    next_state = is_read ? Restart : DataWrite;
            Restart:
                next_state = CtrlRead;
            CtrlRead:
                if (!slave_nack)
                    next_state = DataRead;
            Stop:
                next_state = Ackn;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= Idle;
            is_read   <= 1'b0;
            issued    <= 1'b0;
            nack_flag <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            case (state)
                Idle:
                begin
                    if (wr || rd)
                    begin
                        is_read   <= !wr;   // write wins
                        nack_flag <= 1'b0;
                        state     <= Start;
                    end
                end
                Ackn:
                    state <= Idle;
                default:
                begin
                    if (cmd_done)
                    begin
                        issued    <= 1'b0;
                        nack_flag <= nack_flag | slave_nack;
                        state     <= next_state;
                    end
                    else if (issue)
                    begin
                        cmd_valid <= 1'b1;
                        issued    <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == Idle && (wr || rd))
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (issue)
        begin
            cmd         <= state_cmd;
            tx_byte     <= state_byte;
            master_nack <= (state_cmd == CMD_READ);   // single byte read ends with nack
        end
        if (state == DataRead && cmd_done)
            rdata <= rx_byte;
    end

endmodule

// ==== rtl/eeprom_master.sv ====
module eeprom_master
#(
    parameter int QUARTER_CYCLES = 2
)
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t        wdata,
    output logic                     ack,
    output logic                     nack,
    output eeprom_pkg::byte_t        rdata,
    output logic                     scl,
    output logic                     sda_oe,
    input  logic                     sda_in
);
    import eeprom_pkg::*;

    logic     cmd_valid;
    i2c_cmd_t cmd;
    byte_t    tx_byte;
    logic     master_nack;
    logic     busy;
    logic     cmd_done;
    byte_t    rx_byte;
    logic     slave_nack;

    eeprom_sequencer i_sequencer
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .slave_nack  (slave_nack),
        .ack         (ack),
        .nack        (nack),
        .rdata       (rdata),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .master_nack (master_nack)
    );

    i2c_byte_engine #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) i_engine
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .sda_in      (sda_in),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .slave_nack  (slave_nack),
        .scl         (scl),
        .sda_oe      (sda_oe)
    );

endmodule

// ==== verification/eeprom_slave_model.sv ====
module eeprom_slave_model
(
    input  logic scl,
    input  logic sda,
    input  logic busy,          // withholds every ack
    output logic sda_pull
);
    localparam logic [1:0] PH_CTRL = 2'd0;
    localparam logic [1:0] PH_ADDR = 2'd1;
    localparam logic [1:0] PH_DATA = 2'd2;
    localparam logic [1:0] PH_READ = 2'd3;

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [3:0]  bit_cnt;       // scl rises seen in this byte
    logic [1:0]  phase;
    logic        active;
    logic        master_ack;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'h00;
        ptr        = 11'd0;
        active     = 1'b0;
        sda_pull   = 1'b0;
        bit_cnt    = 4'd0;
        phase      = PH_CTRL;
        master_ack = 1'b0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active   = 1'b1;
            phase    = PH_CTRL;
            bit_cnt  = 4'd0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            active = 1'b0;      // stop
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (bit_cnt < 4'd8 && phase != PH_READ)
                shreg = {shreg[6:0], sda};
            else if (bit_cnt == 4'd8 && phase == PH_READ)
                master_ack = !sda;
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    // all slave output changes happen while scl is low
    always @(negedge scl)
    begin
        if (active)
        begin
            if (bit_cnt == 4'd8)
            begin
                if (phase == PH_READ)
                    sda_pull = 1'b0;    // let the master ack
                else if (busy || (phase == PH_CTRL && shreg[7:4] != 4'b1010))
                    active = 1'b0;      // no ack until the next start
                else
                begin
                    sda_pull = 1'b1;
                    case (phase)
                        PH_CTRL:
                            ptr[10:8] = shreg[3:1];
                        PH_ADDR:
                            ptr[7:0] = shreg;
                        default:
                        begin
                            mem[ptr] = shreg;
                            ptr      = ptr + 11'd1;
                        end
                    endcase
                end
            end
            else if (bit_cnt == 4'd9)
            begin
                sda_pull = 1'b0;
                bit_cnt  = 4'd0;
                if (phase == PH_CTRL)
                    phase = shreg[0] ? PH_READ : PH_ADDR;
                else if (phase == PH_ADDR)
                    phase = PH_DATA;
                else if (phase == PH_READ && !master_ack)
                    active = 1'b0;
                if (active && phase == PH_READ)
                begin
                    shreg    = mem[ptr];
                    ptr      = ptr + 11'd1;
                    sda_pull = !shreg[7];
                end
            end
            else if (phase == PH_READ && bit_cnt != 4'd0)
                sda_pull = !shreg[7 - bit_cnt];
        end
    end

endmodule

// ==== verification/tb_eeprom_master.sv ====
module tb_eeprom_master;
    import eeprom_pkg::*;

    localparam int ACK_TIMEOUT = 2000;  // a read takes roughly 330 cycles
    localparam int NUM_RANDOM  = 60;

    logic         CLK;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    byte_t        wdata;
    logic         ack;
    logic         nack;
    byte_t        rdata;
    logic         scl;
    logic         sda_oe;
    logic         sda;
    logic         slave_pull;
    logic         slave_busy;

    logic [31:0]  lfsr;
    byte_t        ref_mem [0:2047];
    eeprom_addr_t written [$];

    assign sda = !(sda_oe || slave_pull);   // wired-AND with pull-up

    eeprom_master #(
        .QUARTER_CYCLES (2)
    ) i_dut
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .nack   (nack),
        .rdata  (rdata),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda)
    );

    eeprom_slave_model i_slave
    (
        .scl      (scl),
        .sda      (sda),
        .busy     (slave_busy),
        .sda_pull (slave_pull)
    );

    always #2 CLK = ~CLK;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic wait_for_ack(input string what);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge CLK);
            cycles++;
            if (cycles > ACK_TIMEOUT)
            begin
                $display("Timeout: %s did not complete within %0d cycles", what, ACK_TIMEOUT);
                $display("Checks failed");
                $fatal(1, "no ack from the DUT");
            end
        end
        while (ack !== 1'b1);
    endtask

    task automatic do_transaction(input logic do_write, input eeprom_addr_t a, input byte_t d,
                                  output logic got_nack, output byte_t got_rdata);
        @(negedge CLK);
        wr    = do_write;
        rd    = !do_write;
        addr  = a;
        wdata = d;
        wait_for_ack($sformatf("%s of address %h", do_write ? "write" : "read", a));
        got_nack  = nack;
        got_rdata = rdata;
        wr        = 1'b0;
        rd        = 1'b0;
        @(negedge CLK);
        check_value("ack", ack, 1'b0);      // pulse is one cycle wide
    endtask

    task automatic write_and_check(input eeprom_addr_t a, input byte_t d, input logic busy_now);
        logic  got_nack;
        byte_t got_rdata;
        @(negedge CLK);
        slave_busy = busy_now;
        do_transaction(1'b1, a, d, got_nack, got_rdata);
        check_value("nack", got_nack, busy_now);
        if (!busy_now)
        begin
            ref_mem[a] = d;
            written.push_back(a);
        end
    endtask

    task automatic read_and_check(input eeprom_addr_t a, input logic busy_now);
        logic  got_nack;
        byte_t got_rdata;
        @(negedge CLK);
        slave_busy = busy_now;
        do_transaction(1'b0, a, 8'h00, got_nack, got_rdata);
        check_value("nack", got_nack, busy_now);
        if (!busy_now)
            check_value("rdata", got_rdata, ref_mem[a]);
    endtask

    initial
    begin
        logic [31:0]  r_op;
        logic [31:0]  r_addr;
        logic [31:0]  r_data;
        logic [31:0]  r_busy;
        logic [31:0]  r_pick;
        eeprom_addr_t a;
        eeprom_addr_t held_addr;

        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        slave_busy = 1'b0;
        lfsr       = 32'h18ee45b3;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'h00;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // bus idle after reset
        repeat (3) @(negedge CLK);
        check_value("ack", ack, 1'b0);
        check_value("sda_oe", sda_oe, 1'b0);
        check_value("scl", scl, 1'b1);

        write_and_check(11'h5a3, 8'hc7, 1'b0);
        read_and_check(11'h5a3, 1'b0);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            random_bits(1, r_op);
            random_bits(11, r_addr);
            random_bits(8, r_data);
            random_bits(3, r_busy);
            random_bits(4, r_pick);
            a = r_addr[10:0];
            if (r_op[0])
                write_and_check(a, r_data[7:0], r_busy[2:0] == 3'd7);
            else
            begin
                if (r_pick[3])      // half the reads revisit a recent write
                    a = written[written.size() - 1 - (r_pick[2:0] % written.size())];
                read_and_check(a, r_busy[2:0] == 3'd7);
            end
        end

        // a busy device leaves the old byte in memory
        write_and_check(11'h5a3, ~ref_mem[11'h5a3], 1'b1);
        read_and_check(11'h5a3, 1'b0);
        read_and_check(11'h2f0, 1'b1);

        // rd held through Ackn starts a second read
        held_addr = written[written.size() - 1];
        @(negedge CLK);
        slave_busy = 1'b0;
        rd         = 1'b1;
        addr       = 11'h5a3;
        wait_for_ack("first of two back to back reads");
        check_value("nack", nack, 1'b0);
        check_value("rdata", rdata, ref_mem[11'h5a3]);
        addr = held_addr;
        @(negedge CLK);
        check_value("ack", ack, 1'b0);
        wait_for_ack("second of two back to back reads");
        rd = 1'b0;
        check_value("nack", nack, 1'b0);
        check_value("rdata", rdata, ref_mem[held_addr]);
        @(negedge CLK);
        check_value("ack", ack, 1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/eeprom_pkg.sv
rtl/i2c_byte_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_master.sv
verification/eeprom_slave_model.sv
verification/tb_eeprom_master.sv
